// File: list.f
source/exu_pkg.sv
source/exu_issue_if.sv
source/exu_issue.sv
source/int_alu.sv
source/md_sequencer.sv
source/exu_writeback.sv
source/exu_top.sv
test/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - source/exu_pkg.sv
  - source/exu_issue_if.sv
  - source/exu_issue.sv
  - source/int_alu.sv
  - source/md_sequencer.sv
  - source/exu_writeback.sv
  - source/exu_top.sv
  - target: test
    files:
      - test/exu_tb.sv

// File: test/exu_tb.sv
`timescale 1ns/100ps

module exu_tb;
    import exu_pkg::*;

    localparam int period  = 40;
    localparam int n_alu   = 400;
    localparam int n_mul   = 150;
    localparam int n_div   = 150;
    localparam int n_mixed = 300;
    localparam int n_total = n_alu + n_mul + n_div + n_mixed;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              in_valid;
    exu_op_u           op;
    logic [xlen-1:0]   da;
    logic [xlen-1:0]   db;
    logic              alu_valid;
    logic [xlen-1:0]   result;
    logic              less;
    logic              zero;
    logic              result_valid;
    logic              mul_valid;
    logic              mulw;
    logic [1:0]        mul_signed;
    logic [xlen-1:0]   multiplicand;
    logic [xlen-1:0]   multiplier;
    logic              mul_ready;
    logic              mul_out_valid;
    logic [xlen-1:0]   result_hi;
    logic [xlen-1:0]   result_lo;
    logic [xlen-1:0]   dividend;
    logic [xlen-1:0]   divisor;
    logic              divw;
    logic              div_signed;
    logic              div_valid;
    logic              div_ready;
    logic              div_out_valid;
    logic [xlen-1:0]   quotient;
    logic [xlen-1:0]   remainder;

    // reference model state
    md_state_e         m_state;
    logic              m_is_mul;
    logic [xlen-1:0]   m_a;
    logic [xlen-1:0]   m_b;
    logic              m_word;
    logic [1:0]        m_sign;
    logic              m_rv;
    logic [xlen-1:0]   m_result;
    logic              m_less;
    logic              m_zero;
    logic [xlen-1:0]   exp_q[$];

    // responder job
    logic              job_live;
    logic              job_mul;
    int                job_wait;
    logic [xlen-1:0]   job_hi;
    logic [xlen-1:0]   job_lo;

    logic              op_pending;
    exu_op_u           p_op;
    logic [xlen-1:0]   p_a;
    logic [xlen-1:0]   p_b;
    int                issued;
    int                err_cnt;

    exu_top exu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #((n_total * 12 + 40) * period);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // ==============================
    // checking helpers
    // ==============================
    task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] exp);
        err_cnt++;
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_value(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    function automatic logic [xlen-1:0] sext_word(input logic [xlen-1:0] v);
        return {{half_w{v[half_w-1]}}, v[half_w-1:0]};
    endfunction

    // bit 1 marks operand a signed, bit 0 operand b
    function automatic logic [2*xlen-1:0] mul_product(input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b,
                                                      input logic [1:0] sign,
                                                      input logic word);
        logic [xlen-1:0]   x;
        logic [xlen-1:0]   y;
        logic [2*xlen-1:0] wa;
        logic [2*xlen-1:0] wb;
        x = a;
        y = b;
        if (word) begin
            x = sign[1] ? sext_word(a) : {{half_w{1'b0}}, a[half_w-1:0]};
            y = sign[0] ? sext_word(b) : {{half_w{1'b0}}, b[half_w-1:0]};
        end
        wa = sign[1] ? {{xlen{x[xlen-1]}}, x} : {{xlen{1'b0}}, x};
        wb = sign[0] ? {{xlen{y[xlen-1]}}, y} : {{xlen{1'b0}}, y};
        return wa * wb;
    endfunction

    // {remainder, quotient} with the RISC-V divide by zero and overflow values
    function automatic logic [2*xlen-1:0] div_values(input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b,
                                                     input logic sgn, input logic word);
        logic [xlen-1:0] x;
        logic [xlen-1:0] y;
        logic [xlen-1:0] q;
        logic [xlen-1:0] r;
        logic            neg_a;
        logic            neg_b;
        x = a;
        y = b;
        if (word) begin
            x = sgn ? sext_word(a) : {{half_w{1'b0}}, a[half_w-1:0]};
            y = sgn ? sext_word(b) : {{half_w{1'b0}}, b[half_w-1:0]};
        end
        neg_a = sgn && x[xlen-1];
        neg_b = sgn && y[xlen-1];
        if (y == '0) begin
            q = '1;
            r = x;
        end else begin
            // magnitudes, so the most negative dividend over -1 wraps to itself
            q = (neg_a ? -x : x) / (neg_b ? -y : y);
            r = (neg_a ? -x : x) % (neg_b ? -y : y);
            if (neg_a ^ neg_b) q = -q;
            if (neg_a) r = -r;
        end
        if (word) begin
            q = sext_word(q);
            r = sext_word(r);
        end
        return {r, q};
    endfunction

    function automatic logic [xlen-1:0] md_expect(input exu_op_u o, input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        logic [2*xlen-1:0] prod;
        logic [2*xlen-1:0] qr;
        logic [xlen-1:0]   res;
        prod = mul_product(a, b, o.md.sign, o.md.word);
        qr   = div_values(a, b, o.md.sign != sign_uu, o.md.word);
        case (o.md.kind)
            md_mul: res = o.md.word ? sext_word(prod[xlen-1:0]) : prod[xlen-1:0];
            md_mulh: res = prod[2*xlen-1:xlen];
            md_div: res = qr[xlen-1:0];
            default: res = qr[2*xlen-1:xlen];
        endcase
        return res;
    endfunction

    task automatic alu_model(input exu_op_u o, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b, output logic [xlen-1:0] r,
                             output logic l, output logic z);
        logic [xlen:0]   wide;
        logic [xlen-1:0] raw;
        logic [5:0]      sh;
        logic            subtract;
        subtract = (o.alu.func == func_sub) || (o.alu.func == func_slt) ||
                   (o.alu.func == func_sltu);
        // top bit of the 65-bit signed sum is the true sign
        if (subtract) wide = {a[xlen-1], a} - {b[xlen-1], b};
        else wide = {a[xlen-1], a} + {b[xlen-1], b};
        z = (wide[xlen-1:0] == '0);
        l = (o.alu.func == func_sltu) ? (a < b) : wide[xlen];
        sh = o.alu.word ? {1'b0, b[4:0]} : b[5:0];
        case (o.alu.func)
            func_add, func_sub: raw = wide[xlen-1:0];
            func_slt, func_sltu: raw = {{(xlen-1){1'b0}}, l};
            func_and: raw = a & b;
            func_or: raw = a | b;
            func_xor: raw = a ^ b;
            func_sll: raw = a << sh;
            func_srl: raw = a >> sh;
            func_sra: begin
                if (o.alu.word) raw = $signed(sext_word(a)) >>> sh;
                else raw = $signed(a) >>> sh;
            end
            func_pass: raw = b;
            default: raw = '0;
        endcase
        r = o.alu.word ? sext_word(raw) : raw;
    endtask

    // ==============================
    // stimulus
    // ==============================
    // mode 0 alu, 1 mul, 2 div, 3 mixed
    function automatic exu_op_u random_op(input int mode);
        exu_op_u     o;
        logic [31:0] bits;
        int          pick;
        bits = $urandom;
        pick = (mode == 3) ? (bits[31:24] % 3) : mode;
        o = '0;
        if (pick == 0) begin
            o.alu.cls  = cls_alu;
            o.alu.word = bits[0];
            o.alu.func = alu_func_e'(bits[15:8] % 11);
        end else begin
            o.md.cls  = cls_md;
            o.md.word = bits[0];
            if (pick == 1) o.md.kind = bits[1] ? md_mulh : md_mul;
            else o.md.kind = bits[1] ? md_rem : md_div;
            case (bits[7:4] % 3)
                0: o.md.sign = sign_uu;
                1: o.md.sign = sign_su;
                default: o.md.sign = sign_ss;
            endcase
        end
        return o;
    endfunction

    task automatic random_operands(output logic [xlen-1:0] a, output logic [xlen-1:0] b);
        logic [31:0] sel;
        sel = $urandom;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        case (sel[3:0])
            0: b = a;
            1: b = -a;
            2, 3: b = '0;
            4: begin
                a = {1'b1, {(xlen-1){1'b0}}};
                b = '1;
            end
            // word overflow case
            5: begin
                a = {$urandom, 32'h8000_0000};
                b = '1;
            end
            6: begin
                a = {56'b0, sel[15:8]};
                b = {61'b0, sel[18:16]};
            end
            default: ;
        endcase
    endtask

    task automatic check_outputs();
        expect_value("alu_valid", alu_valid, m_state == st_idle);
        expect_value("mul_valid", mul_valid, (m_state == st_request) && m_is_mul);
        expect_value("div_valid", div_valid, (m_state == st_request) && !m_is_mul);
        expect_value("result_valid", result_valid, m_rv);
        expect_value("result", result, m_result);
        expect_value("less", less, m_less);
        expect_value("zero", zero, m_zero);
        if (m_state == st_request && m_is_mul) begin
            expect_value("multiplicand", multiplicand, m_a);
            expect_value("multiplier", multiplier, m_b);
            expect_value("mul_signed", mul_signed, m_sign);
            expect_value("mulw", mulw, m_word);
        end
        if (m_state == st_request && !m_is_mul) begin
            expect_value("dividend", dividend, m_a);
            expect_value("divisor", divisor, m_b);
            expect_value("div_signed", div_signed, m_sign != sign_uu);
            expect_value("divw", divw, m_word);
        end
    endtask

    // one clock of checking, response and stimulus
    task automatic cycle_step(input int n_ops, input int mode, input int flush_rate);
        logic              do_flush;
        logic              take;
        logic              rdy_mul;
        logic              rdy_div;
        logic              out_mul;
        logic              out_div;
        logic [31:0]       rnd;
        logic [xlen-1:0]   ca;
        logic [xlen-1:0]   cb;
        logic [xlen-1:0]   r;
        logic              l;
        logic              z;
        logic [2*xlen-1:0] wide;

        @(negedge clk);
        check_outputs();

        rnd = $urandom;
        do_flush = 1'b0;
        if (flush_rate != 0) begin
            if (m_state != st_idle) do_flush = (rnd[15:0] % flush_rate) == 0;
            else do_flush = (rnd[15:0] % (4 * flush_rate)) == 0;
        end
        if (!op_pending && issued < n_ops && (mode == 0 || rnd[17:16] != 2'b00)) begin
            p_op = random_op(mode);
            random_operands(p_a, p_b);
            op_pending = 1'b1;
        end
        take = op_pending && (m_state == st_idle) && !do_flush;

        // multiplier and divider responder
        rnd = $urandom;
        rdy_mul = rnd[1:0] != 2'b00;
        rdy_div = rnd[3:2] != 2'b00;
        out_mul = 1'b0;
        out_div = 1'b0;
        if (do_flush) begin
            job_live = 1'b0;
        end else if (job_live) begin
            job_wait--;
            if (job_wait == 0) begin
                job_live = 1'b0;
                out_mul  = job_mul;
                out_div  = !job_mul;
            end
        end
        if (!do_flush && mul_valid && rdy_mul) begin
            wide     = mul_product(multiplicand, multiplier, mul_signed, mulw);
            job_hi   = wide[2*xlen-1:xlen];
            job_lo   = mulw ? sext_word(wide[xlen-1:0]) : wide[xlen-1:0];
            job_mul  = 1'b1;
            job_live = 1'b1;
            job_wait = 1 + int'(rnd[6:4]);
        end
        if (!do_flush && div_valid && rdy_div) begin
            wide     = div_values(dividend, divisor, div_signed, divw);
            job_hi   = wide[2*xlen-1:xlen];
            job_lo   = wide[xlen-1:0];
            job_mul  = 1'b0;
            job_live = 1'b1;
            job_wait = 1 + int'(rnd[6:4]);
        end

        // ==============================
        // reference model
        // ==============================
        ca = p_op.alu.word ? {{half_w{1'b0}}, p_a[half_w-1:0]} : p_a;
        cb = p_op.alu.word ? {{half_w{1'b0}}, p_b[half_w-1:0]} : p_b;
        if (do_flush) begin
            m_state  = st_idle;
            m_rv     = 1'b0;
            m_result = '0;
            m_less   = 1'b0;
            m_zero   = 1'b0;
            exp_q.delete();
        end else begin
            m_rv = 1'b0;
            if (take && p_op.alu.cls == cls_alu) begin
                alu_model(p_op, ca, cb, r, l, z);
                m_result = r;
                m_less   = l;
                m_zero   = z;
                m_rv     = 1'b1;
            end else if (take) begin
                m_state  = st_request;
                m_is_mul = (p_op.md.kind == md_mul) || (p_op.md.kind == md_mulh);
                m_a      = ca;
                m_b      = cb;
                m_word   = p_op.md.word;
                m_sign   = p_op.md.sign;
                exp_q.push_back(md_expect(p_op, ca, cb));
            end else if (m_state == st_request) begin
                if (m_is_mul ? rdy_mul : rdy_div) m_state = st_wait;
            end else if (m_state == st_wait && (m_is_mul ? out_mul : out_div)) begin
                m_state  = st_idle;
                m_rv     = 1'b1;
                m_result = exp_q.pop_front();
            end
        end

        flush         = do_flush;
        in_valid      = op_pending;
        op            = p_op;
        da            = p_a;
        db            = p_b;
        mul_ready     = rdy_mul;
        div_ready     = rdy_div;
        mul_out_valid = out_mul;
        div_out_valid = out_div;
        // junk on the result buses outside a valid cycle
        result_hi = out_mul ? job_hi : {$urandom, $urandom};
        result_lo = out_mul ? job_lo : {$urandom, $urandom};
        remainder = out_div ? job_hi : {$urandom, $urandom};
        quotient  = out_div ? job_lo : {$urandom, $urandom};

        if (take) begin
            op_pending = 1'b0;
            issued++;
        end
    endtask

    task automatic run_phase(input int n_ops, input int mode, input int flush_rate);
        issued = 0;
        while (issued < n_ops || op_pending || m_state != st_idle || m_rv) begin
            cycle_step(n_ops, mode, flush_rate);
        end
    endtask

    initial begin
        void'($urandom(13441));
        rst_n         = 1'b0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        op            = '0;
        da            = '0;
        db            = '0;
        mul_ready     = 1'b0;
        mul_out_valid = 1'b0;
        result_hi     = '0;
        result_lo     = '0;
        div_ready     = 1'b0;
        div_out_valid = 1'b0;
        quotient      = '0;
        remainder     = '0;
        m_state       = st_idle;
        m_is_mul      = 1'b0;
        m_rv          = 1'b0;
        m_result      = '0;
        m_less        = 1'b0;
        m_zero        = 1'b0;
        job_live      = 1'b0;
        job_wait      = 0;
        op_pending    = 1'b0;
        p_op          = '0;
        p_a           = '0;
        p_b           = '0;
        issued        = 0;
        err_cnt       = 0;

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // idle state straight after reset
        repeat (2) cycle_step(0, 0, 0);

        run_phase(n_alu, 0, 0);
        run_phase(n_mul, 1, 0);
        run_phase(n_div, 2, 0);
        run_phase(n_mixed, 3, 12);

        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: source/exu_top.sv
`timescale 1ns/100ps

module exu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     in_valid,
    input  exu_pkg::exu_op_u         op,
    input  logic [exu_pkg::xlen-1:0] da,
    input  logic [exu_pkg::xlen-1:0] db,
    output logic                     alu_valid,
    output logic [exu_pkg::xlen-1:0] result,
    output logic                     less,
    output logic                     zero,
    output logic                     result_valid,
    output logic                     mul_valid,
    output logic                     mulw,
    output logic [1:0]               mul_signed,
    output logic [exu_pkg::xlen-1:0] multiplicand,
    output logic [exu_pkg::xlen-1:0] multiplier,
    input  logic                     mul_ready,
    input  logic                     mul_out_valid,
    input  logic [exu_pkg::xlen-1:0] result_hi,
    input  logic [exu_pkg::xlen-1:0] result_lo,
    output logic [exu_pkg::xlen-1:0] dividend,
    output logic [exu_pkg::xlen-1:0] divisor,
    output logic                     divw,
    output logic                     div_signed,
    output logic                     div_valid,
    input  logic                     div_ready,
    input  logic                     div_out_valid,
    input  logic [exu_pkg::xlen-1:0] quotient,
    input  logic [exu_pkg::xlen-1:0] remainder
);
    import exu_pkg::*;

    logic [xlen-1:0] alu_result;
    logic            alu_less;
    logic            alu_zero;
    logic            md_done;
    logic [xlen-1:0] md_result;

    exu_issue_if iss ();

    // ==============================
    // issue, then alu and sequencer
    // ==============================
    exu_issue exu_issue_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .da       (da),
        .db       (db),
        .ready    (alu_valid),
        .flush    (flush),
        .iss      (iss)
    );

    int_alu int_alu_i (
        .iss    (iss),
        .result (alu_result),
        .less   (alu_less),
        .zero   (alu_zero)
    );

    md_sequencer md_sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .iss           (iss),
        .ready         (alu_valid),
        .md_done       (md_done),
        .md_result     (md_result),
        .mul_valid     (mul_valid),
        .mulw          (mulw),
        .mul_signed    (mul_signed),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .result_hi     (result_hi),
        .result_lo     (result_lo),
        .div_valid     (div_valid),
        .dividend      (dividend),
        .divisor       (divisor),
        .divw          (divw),
        .div_signed    (div_signed),
        .div_ready     (div_ready),
        .div_out_valid (div_out_valid),
        .quotient      (quotient),
        .remainder     (remainder)
    );

    // registered results
    exu_writeback exu_writeback_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .iss          (iss),
        .alu_result   (alu_result),
        .alu_less     (alu_less),
        .alu_zero     (alu_zero),
        .md_done      (md_done),
        .md_result    (md_result),
        .result       (result),
        .less         (less),
        .zero         (zero),
        .result_valid (result_valid)
    );

endmodule

// File: source/exu_writeback.sv
`timescale 1ns/100ps

module exu_writeback (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    exu_issue_if.wb                  iss,
    input  logic [exu_pkg::xlen-1:0] alu_result,
    input  logic                     alu_less,
    input  logic                     alu_zero,
    input  logic                     md_done,
    input  logic [exu_pkg::xlen-1:0] md_result,
    output logic [exu_pkg::xlen-1:0] result,
    output logic                     less,
    output logic                     zero,
    output logic                     result_valid
);
    import exu_pkg::*;

    logic alu_take;

    assign alu_take = iss.fire && (iss.op.alu.cls == cls_alu);

    // flags only follow simple ops
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            result       <= '0;
            less         <= 1'b0;
            zero         <= 1'b0;
            result_valid <= 1'b0;
        end else if (alu_take) begin
            result       <= alu_result;
            less         <= alu_less;
            zero         <= alu_zero;
            result_valid <= 1'b1;
        end else if (md_done) begin
            result       <= md_result;
            result_valid <= 1'b1;
        end else begin
            result_valid <= 1'b0;
        end
    end

endmodule

// File: source/md_sequencer.sv
`timescale 1ns/100ps

module md_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    exu_issue_if.seq                 iss,
    output logic                     ready,
    output logic                     md_done,
    output logic [exu_pkg::xlen-1:0] md_result,
    output logic                     mul_valid,
    output logic                     mulw,
    output logic [1:0]               mul_signed,
    output logic [exu_pkg::xlen-1:0] multiplicand,
    output logic [exu_pkg::xlen-1:0] multiplier,
    input  logic                     mul_ready,
    input  logic                     mul_out_valid,
    input  logic [exu_pkg::xlen-1:0] result_hi,
    input  logic [exu_pkg::xlen-1:0] result_lo,
    output logic                     div_valid,
    output logic [exu_pkg::xlen-1:0] dividend,
    output logic [exu_pkg::xlen-1:0] divisor,
    output logic                     divw,
    output logic                     div_signed,
    input  logic                     div_ready,
    input  logic                     div_out_valid,
    input  logic [exu_pkg::xlen-1:0] quotient,
    input  logic [exu_pkg::xlen-1:0] remainder
);
    import exu_pkg::*;

    md_state_e       state;
    md_state_e       state_nxt;
    md_kind_e        kind_q;
    md_sign_e        sign_q;
    logic            word_q;
    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    logic            start;
    logic            is_mul;
    logic            req_done;
    logic            out_seen;
    logic [xlen-1:0] lo_sel;

    assign start    = iss.fire && (iss.op.md.cls == cls_md);
    assign is_mul   = (kind_q == md_mul) || (kind_q == md_mulh);
    assign req_done = is_mul ? (mul_valid && mul_ready) : (div_valid && div_ready);
    assign out_seen = is_mul ? mul_out_valid : div_out_valid;

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_request;
                end
            end
            st_request: begin
                if (req_done) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (out_seen) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind_q <= md_mul;
        end else if (start) begin
            kind_q <= iss.op.md.kind;
        end
    end

    // operands held for the whole request
    always_ff @(posedge clk) begin
        if (start) begin
            a_q    <= iss.a;
            b_q    <= iss.b;
            word_q <= iss.op.md.word;
            sign_q <= iss.op.md.sign;
        end
    end

    // ==============================
    // external ports
    // ==============================
    assign ready     = (state == st_idle);
    assign mul_valid = (state == st_request) && is_mul;
    assign div_valid = (state == st_request) && !is_mul;

    assign mulw         = word_q;
    assign mul_signed   = sign_q;
    assign multiplicand = a_q;
    assign multiplier   = b_q;

    assign divw       = word_q;
    assign div_signed = (sign_q != sign_uu);
    assign dividend   = a_q;
    assign divisor    = b_q;

    // result select
    assign lo_sel  = word_q ? {{half_w{result_lo[half_w-1]}}, result_lo[half_w-1:0]} : result_lo;
    assign md_done = (state == st_wait) && out_seen;

    always_comb begin
        case (kind_q)
            md_mulh: md_result = result_hi;
            md_mul: md_result = lo_sel;
            md_rem: md_result = remainder;
            default: md_result = quotient;
        endcase
    end

endmodule

// File: source/int_alu.sv
`timescale 1ns/100ps

module int_alu (
    exu_issue_if.alu                 iss,
    output logic [exu_pkg::xlen-1:0] result,
    output logic                     less,
    output logic                     zero
);
    import exu_pkg::*;

    logic               sub_mode;
    logic [xlen-1:0]    b_inv;
    logic [xlen-1:0]    sum;
    logic               carry;
    logic               ovf;
    logic [shamt_w-1:0] shamt;
    logic [half_w-1:0]  sra_w;
    logic [xlen-1:0]    sra_d;
    logic [xlen-1:0]    raw;

    // ==============================
    // adder and compare
    // ==============================
    // sub and both compares go through the subtractor
    assign sub_mode = (iss.op.alu.func == func_sub) || (iss.op.alu.func == func_slt) ||
                      (iss.op.alu.func == func_sltu);

    assign b_inv = iss.b ^ {xlen{sub_mode}};
    assign {carry, sum} = {1'b0, iss.a} + {1'b0, b_inv} + {{xlen{1'b0}}, sub_mode};

    assign ovf  = (iss.a[xlen-1] == b_inv[xlen-1]) && (iss.a[xlen-1] != sum[xlen-1]);
    assign less = (iss.op.alu.func == func_sltu) ? (carry ^ sub_mode) : (ovf ^ sum[xlen-1]);
    assign zero = (sum == '0);

    // ==============================
    // shifter
    // ==============================
    // five amount bits in word mode
    assign shamt = iss.op.alu.word ? {1'b0, iss.b[4:0]} : iss.b[shamt_w-1:0];

    assign sra_w = $signed(iss.a[half_w-1:0]) >>> shamt[4:0];
    assign sra_d = $signed(iss.a) >>> shamt;

    always_comb begin
        case (iss.op.alu.func)
            func_add, func_sub: raw = sum;
            func_slt, func_sltu: raw = {{(xlen-1){1'b0}}, less};
            func_and: raw = iss.a & iss.b;
            func_or: raw = iss.a | iss.b;
            func_xor: raw = iss.a ^ iss.b;
            func_sll: raw = iss.a << shamt;
            // zero-extended low half makes the 64-bit srl right for words too
            func_srl: raw = iss.a >> shamt;
            func_sra: begin
                if (iss.op.alu.word) begin
                    raw = {{half_w{1'b0}}, sra_w};
                end else begin
                    raw = sra_d;
                end
            end
            func_pass: raw = iss.b;
            default: raw = '0;
        endcase
    end

    // word results sign extended from bit 31
    assign result = iss.op.alu.word ? {{half_w{raw[half_w-1]}}, raw[half_w-1:0]} : raw;

endmodule

// File: source/exu_issue.sv
`timescale 1ns/100ps

module exu_issue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  exu_pkg::exu_op_u         op,
    input  logic [exu_pkg::xlen-1:0] da,
    input  logic [exu_pkg::xlen-1:0] db,
    input  logic                     ready,
    input  logic                     flush,
    exu_issue_if.issuer              iss
);
    import exu_pkg::*;

    logic word;

    // word bit sits in the same place in both views
    assign word = op.alu.word;

    // ==============================
    // accept and condition
    // ==============================
    assign iss.fire = in_valid && ready && !flush;
    assign iss.op   = op;

    // word mode keeps only the zero-extended low half
    assign iss.a = word ? {{half_w{1'b0}}, da[half_w-1:0]} : da;
    assign iss.b = word ? {{half_w{1'b0}}, db[half_w-1:0]} : db;

endmodule

// File: source/exu_issue_if.sv
`timescale 1ns/100ps

interface exu_issue_if;
    import exu_pkg::*;

    logic            fire;
    exu_op_u         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;

    modport issuer (output fire, output op, output a, output b);

    modport alu (input op, input a, input b);

    modport seq (input fire, input op, input a, input b);

    modport wb (input fire, input op);

endinterface

// File: source/exu_pkg.sv
package exu_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int unsigned xlen    = 64;
    localparam int unsigned half_w  = 32;
    localparam int unsigned shamt_w = 6;

    // ==============================
    // opcode fields
    // ==============================
    typedef enum logic {
        cls_alu = 1'b0,
        cls_md  = 1'b1
    } op_cls_e;

    typedef enum logic [3:0] {
        func_add  = 4'h0,
        func_sub  = 4'h1,
        func_slt  = 4'h2,
        func_sltu = 4'h3,
        func_and  = 4'h4,
        func_or   = 4'h5,
        func_xor  = 4'h6,
        func_sll  = 4'h7,
        func_srl  = 4'h8,
        func_sra  = 4'h9,
        func_pass = 4'ha
    } alu_func_e;

    typedef enum logic [1:0] {
        md_mul  = 2'b00,
        md_mulh = 2'b01,
        md_div  = 2'b10,
        md_rem  = 2'b11
    } md_kind_e;

    // divide and remainder treat any nonzero value as signed
    typedef enum logic [1:0] {
        sign_uu = 2'b00,
        sign_su = 2'b10,
        sign_ss = 2'b11
    } md_sign_e;

    typedef struct packed {
        op_cls_e   cls;
        logic      word;
        alu_func_e func;
    } alu_op_s;

    typedef struct packed {
        op_cls_e  cls;
        logic     word;
        md_kind_e kind;
        md_sign_e sign;
    } md_op_s;

    // cls in the top bit picks the view
    typedef union packed {
        alu_op_s alu;
        md_op_s  md;
    } exu_op_u;

    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_request = 2'b01,
        st_wait    = 2'b10
    } md_state_e;

endpackage
